// File: include/riscv_address_params.svh
`ifndef RISCV_ADDRESS_PARAMS_SVH
`define RISCV_ADDRESS_PARAMS_SVH

// Word width of the core
`define XLEN        32

// Fetch address after reset
`define RESET_PC    32'h0000_0000

// RV32I major opcodes handled by the address stage
// Grouped as inst[6:5]_inst[4:2]_inst[1:0]
`define OPC_LOAD    7'b00_000_11
`define OPC_STORE   7'b01_000_11
`define OPC_BRANCH  7'b11_000_11
`define OPC_JALR    7'b11_001_11
`define OPC_JAL     7'b11_011_11

`endif

// File: riscv_address_unit.f
+incdir+include
rtl/riscv_address_pkg.sv
rtl/kogge_stone_adder.sv
rtl/immediate_decoder.sv
rtl/address_generator.sv
rtl/branch_comparator.sv
rtl/address_control.sv
rtl/riscv_address_unit.sv
tests/riscv_address_unit_tb.sv

// File: rtl/address_control.sv
`timescale 1ns/10ps

`include "riscv_address_params.svh"

module address_control
    import riscv_address_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_valid,
    input  opcode_t i_opcode,
    input  word_t   i_target,
    input  word_t   i_pc_plus4,
    input  logic    i_taken,
    output word_t   o_pc,
    output word_t   o_mem_addr,
    output logic    o_mem_rd,
    output logic    o_mem_wr,
    output word_t   o_link,
    output logic    o_link_wr
);

    logic  is_load;
    logic  is_store;
    logic  is_jump;
    logic  redirect;
    word_t next_pc;

    assign is_load  = (i_opcode == `OPC_LOAD);
    assign is_store = (i_opcode == `OPC_STORE);
    assign is_jump  = (i_opcode == `OPC_JAL) || (i_opcode == `OPC_JALR);

    // Jumps always redirect, branches only when the condition holds
    assign redirect = is_jump || ((i_opcode == `OPC_BRANCH) && i_taken);
    assign next_pc  = redirect ? i_target : i_pc_plus4;

    // Program counter
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `RESET_PC;
        end else if (i_valid) begin
            o_pc <= next_pc;
        end
    end

    // One-cycle strobes that drop on idle cycles
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_rd  <= 1'b0;
            o_mem_wr  <= 1'b0;
            o_link_wr <= 1'b0;
        end else begin
            o_mem_rd  <= i_valid && is_load;
            o_mem_wr  <= i_valid && is_store;
            o_link_wr <= i_valid && is_jump;
        end
    end

    // Memory address holds until the next load or store
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_addr <= '0;
        end else if (i_valid && (is_load || is_store)) begin
            o_mem_addr <= i_target;
        end
    end

    // Return address for JAL and JALR
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_link <= '0;
        end else if (i_valid && is_jump) begin
            o_link <= i_pc_plus4;
        end
    end

endmodule

// File: rtl/address_generator.sv
`timescale 1ns/10ps

`include "riscv_address_params.svh"

module address_generator
    import riscv_address_pkg::*;
(
    input  opcode_t i_opcode,
    input  word_t   i_pc,
    input  word_t   i_rs1,
    input  word_t   i_imm,
    output word_t   o_target
);

    word_t base;
    word_t sum;

    // pc-relative for branches and JAL, register-relative otherwise
    assign base = ((i_opcode == `OPC_BRANCH) || (i_opcode == `OPC_JAL)) ? i_pc : i_rs1;

    kogge_stone_adder target_adder_i (
        .i_a   (base),
        .i_b   (i_imm),
        .o_sum (sum)
    );

    always_comb begin
        case (i_opcode)
            `OPC_LOAD,
            `OPC_STORE,
            `OPC_BRANCH,
            `OPC_JAL: o_target = sum;
            // JALR target has its lsb cleared
            `OPC_JALR: o_target = {sum[`XLEN-1:1], 1'b0};
            default: o_target = '0;
        endcase
    end

endmodule

// File: rtl/branch_comparator.sv
`timescale 1ns/10ps

module branch_comparator
    import riscv_address_pkg::*;
(
    input  funct3_t i_funct3,
    input  word_t   i_rs1,
    input  word_t   i_rs2,
    output logic    o_taken
);

    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal         = (i_rs1 == i_rs2);
    assign less_signed   = ($signed(i_rs1) < $signed(i_rs2));
    assign less_unsigned = (i_rs1 < i_rs2);

    always_comb begin
        case (i_funct3)
            3'b000: o_taken = equal;            // BEQ
            3'b001: o_taken = !equal;           // BNE
            3'b100: o_taken = less_signed;      // BLT
            3'b101: o_taken = !less_signed;     // BGE
            3'b110: o_taken = less_unsigned;    // BLTU
            3'b111: o_taken = !less_unsigned;   // BGEU
            // 010 and 011 are not branches
            default: o_taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/immediate_decoder.sv
`timescale 1ns/10ps

`include "riscv_address_params.svh"

module immediate_decoder
    import riscv_address_pkg::*;
(
    input  instr_t i_instr,
    output word_t  o_imm
);

    opcode_t opcode;
    logic    sign;

    assign opcode = i_instr[6:0];
    assign sign   = i_instr[31];

    always_comb begin
        case (opcode)
            // I-type
            `OPC_LOAD,
            `OPC_JALR: begin
                o_imm = {{20{sign}}, i_instr[31:20]};
            end
            // S-type offset split around rs2
            `OPC_STORE: begin
                o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            end
            // B-type halfword offset
            `OPC_BRANCH: begin
                o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
            end
            // J-type halfword offset
            `OPC_JAL: begin
                o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

// File: rtl/kogge_stone_adder.sv
`timescale 1ns/10ps

module kogge_stone_adder (
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    output logic [31:0] o_sum
);

    localparam int LEVELS = 5;

    // Group propagate is only needed up to the next-to-last level
    logic [31:0] p_lvl [0:LEVELS-1];
    logic [31:0] g_lvl [0:LEVELS];

    // Bitwise propagate and generate
    assign p_lvl[0] = i_a ^ i_b;
    assign g_lvl[0] = i_a & i_b;

    genvar lvl;
    genvar bit_i;

    generate
        for (lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
            localparam int DIST = 1 << (lvl - 1);

            for (bit_i = 0; bit_i < 32; bit_i++) begin : g_bit
                if (bit_i < DIST) begin : g_pass
                    // Span already reaches bit 0
                    assign g_lvl[lvl][bit_i] = g_lvl[lvl-1][bit_i];
                    if (lvl < LEVELS) begin : g_pass_p
                        assign p_lvl[lvl][bit_i] = p_lvl[lvl-1][bit_i];
                    end
                end else begin : g_cell
                    // Generate half of the cell
                    assign g_lvl[lvl][bit_i] = g_lvl[lvl-1][bit_i]
                        | (p_lvl[lvl-1][bit_i] & g_lvl[lvl-1][bit_i-DIST]);
                    // Black cell also merges propagate
                    if (lvl < LEVELS) begin : g_black
                        assign p_lvl[lvl][bit_i] = p_lvl[lvl-1][bit_i]
                            & p_lvl[lvl-1][bit_i-DIST];
                    end
                end
            end
        end
    endgenerate

    // Carry into bit i is the group generate of bits i-1 down to 0
    assign o_sum[0]    = p_lvl[0][0];
    assign o_sum[31:1] = p_lvl[0][31:1] ^ g_lvl[LEVELS][30:0];

endmodule

// File: rtl/riscv_address_pkg.sv
`include "riscv_address_params.svh"

package riscv_address_pkg;

    // Data and address word
    typedef logic [`XLEN-1:0] word_t;

    // Major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // Minor function field, instr[14:12]
    typedef logic [2:0] funct3_t;

    // Raw 32-bit instruction as it leaves decode
    typedef logic [31:0] instr_t;

endpackage

// File: rtl/riscv_address_unit.sv
`timescale 1ns/10ps

module riscv_address_unit
    import riscv_address_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  instr_t i_instr,
    input  word_t  i_rs1,
    input  word_t  i_rs2,
    output word_t  o_pc,
    output word_t  o_mem_addr,
    output logic   o_mem_rd,
    output logic   o_mem_wr,
    output word_t  o_link,
    output logic   o_link_wr
);

    opcode_t opcode;
    funct3_t funct3;
    word_t   imm;
    word_t   target;
    word_t   pc_plus4;
    logic    taken;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];

    immediate_decoder imm_dec_i (
        .i_instr (i_instr),
        .o_imm   (imm)
    );

    address_generator addr_gen_i (
        .i_opcode (opcode),
        .i_pc     (o_pc),
        .i_rs1    (i_rs1),
        .i_imm    (imm),
        .o_target (target)
    );

    branch_comparator branch_cmp_i (
        .i_funct3 (funct3),
        .i_rs1    (i_rs1),
        .i_rs2    (i_rs2),
        .o_taken  (taken)
    );

    // Sequential pc
    kogge_stone_adder pc_adder_i (
        .i_a   (o_pc),
        .i_b   (word_t'(4)),
        .o_sum (pc_plus4)
    );

    address_control ctrl_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_opcode   (opcode),
        .i_target   (target),
        .i_pc_plus4 (pc_plus4),
        .i_taken    (taken),
        .o_pc       (o_pc),
        .o_mem_addr (o_mem_addr),
        .o_mem_rd   (o_mem_rd),
        .o_mem_wr   (o_mem_wr),
        .o_link     (o_link),
        .o_link_wr  (o_link_wr)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is judged from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f riscv_address_unit.f \
    --top-module riscv_address_unit_tb -o riscv_address_unit_sim &&
    ./obj_dir/riscv_address_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1

// File: tests/riscv_address_unit_tb.sv
`timescale 1ns/10ps

`include "riscv_address_params.svh"

module riscv_address_unit_tb
    import riscv_address_pkg::*;
();

    localparam int SWEEP_PAIRS    = 200;
    // The tests run for roughly 250 cycles
    localparam int TIMEOUT_CYCLES = 400;
    localparam opcode_t OPC_OP     = 7'b01_100_11;
    localparam opcode_t OPC_OP_IMM = 7'b00_100_11;

    logic   clk;
    logic   rst_n;
    logic   valid;
    instr_t instr;
    word_t  rs1;
    word_t  rs2;
    word_t  pc;
    word_t  mem_addr;
    logic   mem_rd;
    logic   mem_wr;
    word_t  link;
    logic   link_wr;

    // Reference model state
    word_t  model_pc;
    word_t  model_mem_addr;
    word_t  model_link;
    int     cycle_count;
    int     seed_value;

    riscv_address_unit dut_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (valid),
        .i_instr    (instr),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_pc       (pc),
        .o_mem_addr (mem_addr),
        .o_mem_rd   (mem_rd),
        .o_mem_wr   (mem_wr),
        .o_link     (link),
        .o_link_wr  (link_wr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got 0x%08h expected 0x%08h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input logic exp_rd, input logic exp_wr, input logic exp_lw);
        check_value("o_pc", pc, model_pc);
        check_value("o_mem_addr", mem_addr, model_mem_addr);
        check_value("o_mem_rd", {31'd0, mem_rd}, {31'd0, exp_rd});
        check_value("o_mem_wr", {31'd0, mem_wr}, {31'd0, exp_wr});
        check_value("o_link", link, model_link);
        check_value("o_link_wr", {31'd0, link_wr}, {31'd0, exp_lw});
    endtask

    // Instruction encoders use rd = x1, rs1 = x2 and rs2 = x3
    function automatic instr_t enc_i(input opcode_t opc, input funct3_t f3, input word_t imm);
        return {imm[11:0], 5'd2, f3, 5'd1, opc};
    endfunction

    function automatic instr_t enc_s(input funct3_t f3, input word_t imm);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic instr_t enc_b(input funct3_t f3, input word_t imm);
        return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input word_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OPC_JAL};
    endfunction

    function automatic word_t rand_imm12();
        logic [11:0] r;
        r = 12'($urandom());
        return {{20{r[11]}}, r};
    endfunction

    function automatic logic branch_rule(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Drives one instruction for one cycle and checks the registered results
    task automatic issue(input instr_t instr_word, input word_t a, input word_t b,
                         input word_t imm);
        opcode_t opc;
        word_t   next_pc;
        opc     = instr_word[6:0];
        next_pc = model_pc + 32'd4;
        case (opc)
            `OPC_BRANCH: if (branch_rule(instr_word[14:12], a, b)) next_pc = model_pc + imm;
            `OPC_JAL:    next_pc = model_pc + imm;
            `OPC_JALR:   next_pc = (a + imm) & ~32'd1;
            default:     ;
        endcase
        if (opc == `OPC_LOAD || opc == `OPC_STORE) model_mem_addr = a + imm;
        if (opc == `OPC_JAL || opc == `OPC_JALR) model_link = model_pc + 32'd4;
        instr = instr_word;
        rs1   = a;
        rs2   = b;
        valid = 1'b1;
        @(posedge clk);
        #2;
        valid    = 1'b0;
        model_pc = next_pc;
        check_outputs(opc == `OPC_LOAD, opc == `OPC_STORE,
                      opc == `OPC_JAL || opc == `OPC_JALR);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            check_outputs(1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic test_reset_idle();
        check_value("o_pc", pc, `RESET_PC);
        idle(3);
    endtask

    task automatic test_load_store();
        issue(enc_i(`OPC_LOAD, 3'b010, 32'hFFFF_FFFC), $urandom(), 0, 32'hFFFF_FFFC);
        issue(enc_s(3'b010, 32'd2047), $urandom(), $urandom(), 32'd2047);
        for (int n = 0; n < 4; n++) begin
            word_t imm;
            imm = rand_imm12();
            issue(enc_i(`OPC_LOAD, 3'b010, imm), $urandom(), 0, imm);
            imm = rand_imm12();
            issue(enc_s(3'b010, imm), $urandom(), $urandom(), imm);
        end
        idle(1);
    endtask

    task automatic test_add_sweep();
        word_t corner_a [4] = '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'd1, 32'h0000_F800};
        word_t corner_b [4] = '{32'd1, 32'd1, 32'hFFFF_FFFF, 32'hFFFF_F800};
        word_t a;
        word_t b;
        for (int n = 0; n < SWEEP_PAIRS; n++) begin
            if (n < 4) begin
                a = corner_a[n];
                b = corner_b[n];
            end else begin
                a = $urandom();
                b = rand_imm12();
            end
            issue(enc_i(`OPC_LOAD, 3'b010, b), a, 0, b);
        end
    endtask

    task automatic test_branches();
        funct3_t codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        word_t   lhs [3]   = '{32'h0000_1234, 32'h8000_0000, 32'h0000_0000};
        word_t   rhs [3]   = '{32'h0000_1234, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
        word_t   offs [3]  = '{32'h0000_0800, 32'hFFFF_FFF8, 32'h0000_0014};
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 3; k++) begin
                issue(enc_b(codes[c], offs[k]), lhs[k], rhs[k], offs[k]);
            end
        end
    endtask

    task automatic test_jumps();
        issue(enc_j(32'h0001_2346), $urandom(), $urandom(), 32'h0001_2346);
        idle(1);
        issue(enc_j(32'hFFFF_FFC0), $urandom(), $urandom(), 32'hFFFF_FFC0);
        idle(1);
        // Odd sums show the cleared lsb
        issue(enc_i(`OPC_JALR, 3'b000, 32'd4), 32'h0000_1001, 0, 32'd4);
        idle(1);
        issue(enc_i(`OPC_JALR, 3'b000, 32'hFFFF_FFFD), 32'h0000_2000, 0, 32'hFFFF_FFFD);
        idle(1);
    endtask

    task automatic test_back_to_back();
        instr_t op_word;
        op_word = {7'd0, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP};
        issue(op_word, $urandom(), $urandom(), 0);
        issue(enc_i(`OPC_LOAD, 3'b010, 32'd8), $urandom(), 0, 32'd8);
        issue(enc_i(OPC_OP_IMM, 3'b000, 32'd5), $urandom(), 0, 0);
        issue(enc_s(3'b010, 32'hFFFF_FFF0), $urandom(), $urandom(), 32'hFFFF_FFF0);
        issue(enc_s(3'b000, 32'd3), $urandom(), $urandom(), 32'd3);
        issue(op_word, $urandom(), $urandom(), 0);
        issue(enc_i(`OPC_LOAD, 3'b000, 32'd1), $urandom(), 0, 32'd1);
        issue(enc_i(OPC_OP_IMM, 3'b000, 32'd7), $urandom(), 0, 0);
        idle(2);
    endtask

    initial begin
        seed_value     = $urandom(78972);
        rst_n          = 1'b0;
        valid          = 1'b0;
        instr          = '0;
        rs1            = '0;
        rs2            = '0;
        model_pc       = `RESET_PC;
        model_mem_addr = '0;
        model_link     = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_idle();
        test_load_store();
        test_add_sweep();
        test_branches();
        test_jumps();
        test_back_to_back();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
